/* rv32_pipeline_core.f */
hw/rv32_pkg.sv
hw/fetch.sv
hw/register_file.sv
hw/decode.sv
hw/hazard_unit.sv
hw/execute.sv
hw/write_back.sv
hw/rv32_pipeline_core.sv
verif/clock_gen.sv
verif/rv32_pipeline_core_sva.sv
verif/rv32_pipeline_core_tb.sv

/* Bender.yml */
package:
  name: rv32_pipeline_core

sources:
  - files:
      - hw/rv32_pkg.sv
      - hw/fetch.sv
      - hw/register_file.sv
      - hw/decode.sv
      - hw/hazard_unit.sv
      - hw/execute.sv
      - hw/write_back.sv
      - hw/rv32_pipeline_core.sv
  - target: test
    files:
      - verif/clock_gen.sv
      - verif/rv32_pipeline_core_sva.sv
      - verif/rv32_pipeline_core_tb.sv

/* verif/rv32_pipeline_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_pipeline_core_tb
  import rv32_pkg::*;
  ;

  typedef struct packed {
    addr_t    addr;
    data_t    data;
    byte_en_t be;
  } store_t;

  // one program word, plus the store it should put on the data port
  typedef struct packed {
    instr_t instr;
    logic   has_store;
    store_t store;
  } row_t;

  logic     clk;
  logic     reset;
  addr_t    memory_instr_address;
  instr_t   memory_instr_read_data;
  addr_t    memory_data_address;
  data_t    memory_data_write_data;
  byte_en_t memory_data_write_enable;
  data_t    memory_data_read_data;

  row_t   program_rows[$];
  store_t expected_stores[$];
  instr_t imem [0:63];
  data_t  dmem [0:63];
  int     imem_words = 0;
  int     store_count = 0;
  int     repeat_count = 0;
  int     expected_repeats = 2;
  logic   fetch_started = 1'b0;
  addr_t  prev_fetch;
  integer seed;

  clock_gen clock_gen_i
    ( .clk   ( clk   )
    , .reset ( reset )
    );

  rv32_pipeline_core rv32_pipeline_core_i
    ( .clk                      ( clk                      )
    , .reset                    ( reset                    )
    , .memory_instr_address     ( memory_instr_address     )
    , .memory_instr_read_data   ( memory_instr_read_data   )
    , .memory_data_address      ( memory_data_address      )
    , .memory_data_write_data   ( memory_data_write_data   )
    , .memory_data_write_enable ( memory_data_write_enable )
    , .memory_data_read_data    ( memory_data_read_data    )
    );

  // rv32 encodings
  function automatic instr_t alu_r
    (logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t alu_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic instr_t load_word(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic instr_t store_op
    (logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  // preload hash over the byte address
  function automatic data_t fill_word(addr_t a);
    return a * 32'h9e37_79b1 + 32'h0000_1357;
  endfunction

  // bound checker on the core ports
  function automatic int assertion_failures();
    return rv32_pipeline_core_i.rv32_pipeline_core_sva_i.failures;
  endfunction

  task automatic push_instr(input instr_t instr);
    row_t row;
    row = '0;
    row.instr = instr;
    program_rows.push_back(row);
  endtask

  task automatic expect_store
    (input instr_t instr, input addr_t addr, input data_t data, input byte_en_t be);
    row_t row;
    row.instr      = instr;
    row.has_store  = 1'b1;
    row.store.addr = addr;
    row.store.data = data;
    row.store.be   = be;
    program_rows.push_back(row);
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_store(input addr_t addr, input data_t data, input byte_en_t be);
    store_t exp;
    if (store_count >= expected_stores.size()) begin
      abort_run($sformatf("[FAIL] %0t ns: unexpected store to %h", $time, addr));
    end else begin
      exp = expected_stores[store_count];
      if (addr !== exp.addr || data !== exp.data || be !== exp.be)
        abort_run($sformatf("[FAIL] %0t ns: store %0d got %h/%h/%b, expected %h/%h/%b",
                            $time, store_count, addr, data, be, exp.addr, exp.data, exp.be));
      else
        store_count++;
    end
  endtask

  task automatic check_fetch(input addr_t addr);
    if (!fetch_started) begin
      if (addr !== 32'h0)
        abort_run($sformatf("[FAIL] %0t ns: instruction address %h, expected 0", $time, addr));
    end else if (addr === prev_fetch) begin
      repeat_count++;
    end else if (addr !== prev_fetch + 32'd4) begin
      abort_run($sformatf("[FAIL] %0t ns: instruction address %h after %h",
                          $time, addr, prev_fetch));
    end
    prev_fetch = addr;
  endtask

  // instruction memory, nop past the end of the program
  assign memory_instr_read_data = (memory_instr_address[31:2] < imem_words) ?
                                  imem[memory_instr_address[7:2]] : NOP_INSTR;

  // data memory, byte-lane writes on the clock, combinational read
  assign memory_data_read_data = dmem[memory_data_address[7:2]];

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 64; i++)
        dmem[i] <= fill_word(addr_t'(i * 4));
    end else begin
      for (int l = 0; l < 4; l++)
        if (memory_data_write_enable[l])
          dmem[memory_data_address[7:2]][8*l +: 8] <= memory_data_write_data[8*l +: 8];
    end
  end

  // sampled mid-cycle, outputs come straight off stage registers
  always @(negedge clk) begin
    // clk leaving X at time zero is no clock edge yet
    if ($time > 0) begin
      if (assertion_failures() != 0)
        abort_run("a bound assertion on the core ports failed");
      if (reset || !fetch_started) begin
        if (memory_data_write_enable !== '0)
          abort_run($sformatf("[FAIL] %0t ns: write enables %b around reset",
                              $time, memory_data_write_enable));
      end else if (memory_data_write_enable !== '0) begin
        check_store(memory_data_address, memory_data_write_data, memory_data_write_enable);
      end
      check_fetch(memory_instr_address);
      if (!reset)
        fetch_started = 1'b1;
    end
  end

  initial begin
    int          cycles;
    logic [11:0] imm;
    data_t       sum;
    seed = 32'h1be8_cca6;
    // x1 = 0x123, then add/sub/and/or/xor each on the last result
    push_instr(alu_i(3'b000, 5'd1, 5'd0, 12'h123));
    push_instr(alu_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
    push_instr(alu_r(7'h20, 3'b000, 5'd3, 5'd1, 5'd2));
    push_instr(alu_r(7'h00, 3'b111, 5'd4, 5'd3, 5'd2));
    push_instr(alu_r(7'h00, 3'b110, 5'd5, 5'd4, 5'd1));
    push_instr(alu_r(7'h00, 3'b100, 5'd6, 5'd5, 5'd3));
    // newest first, so x6 comes from the mem stage
    expect_store(store_op(3'b010, 5'd6, 5'd0, 12'h050), 32'h50, 32'hffff_fdba, 4'b1111);
    expect_store(store_op(3'b010, 5'd5, 5'd0, 12'h04c), 32'h4c, 32'h0000_0367, 4'b1111);
    expect_store(store_op(3'b010, 5'd4, 5'd0, 12'h048), 32'h48, 32'h0000_0244, 4'b1111);
    expect_store(store_op(3'b010, 5'd3, 5'd0, 12'h044), 32'h44, 32'hffff_fedd, 4'b1111);
    expect_store(store_op(3'b010, 5'd2, 5'd0, 12'h040), 32'h40, 32'h0000_0246, 4'b1111);
    // xori / andi with negative imm / ori
    push_instr(alu_i(3'b100, 5'd7, 5'd6, 12'h0f0));
    push_instr(alu_i(3'b111, 5'd8, 5'd7, 12'hff0));
    push_instr(alu_i(3'b110, 5'd9, 5'd8, 12'h00a));
    expect_store(store_op(3'b010, 5'd9, 5'd0, 12'h054), 32'h54, 32'hffff_fd4a, 4'b1111);
    expect_store(store_op(3'b010, 5'd8, 5'd0, 12'h058), 32'h58, 32'hffff_fd40, 4'b1111);
    // load-use, one bubble
    push_instr(load_word(5'd10, 5'd0, 12'h080));
    push_instr(alu_r(7'h00, 3'b000, 5'd11, 5'd10, 5'd1));
    expect_store(store_op(3'b010, 5'd11, 5'd0, 12'h05c), 32'h5c,
                 fill_word(32'h80) + 32'h123, 4'b1111);
    // one sb per lane, then read back the merged word
    push_instr(alu_i(3'b000, 5'd12, 5'd0, 12'h7a5));
    expect_store(store_op(3'b000, 5'd12, 5'd0, 12'h060), 32'h60, 32'ha5a5_a5a5, 4'b0001);
    push_instr(alu_i(3'b000, 5'd13, 5'd0, 12'h03c));
    expect_store(store_op(3'b000, 5'd13, 5'd0, 12'h061), 32'h61, 32'h3c3c_3c3c, 4'b0010);
    push_instr(alu_i(3'b000, 5'd14, 5'd0, 12'hfff));
    expect_store(store_op(3'b000, 5'd14, 5'd0, 12'h062), 32'h62, 32'hffff_ffff, 4'b0100);
    expect_store(store_op(3'b000, 5'd1, 5'd0, 12'h063), 32'h63, 32'h2323_2323, 4'b1000);
    push_instr(load_word(5'd15, 5'd0, 12'h060));
    // store data is the loaded reg, second bubble
    expect_store(store_op(3'b010, 5'd15, 5'd0, 12'h064), 32'h64, 32'h23ff_3ca5, 4'b1111);
    // lui + ori constant, writes to x0 dropped
    push_instr({20'h12345, 5'd16, 7'b0110111});
    push_instr(alu_i(3'b110, 5'd17, 5'd16, 12'h678));
    expect_store(store_op(3'b010, 5'd17, 5'd0, 12'h068), 32'h68, 32'h1234_5678, 4'b1111);
    push_instr(alu_i(3'b000, 5'd0, 5'd0, 12'h055));
    push_instr(alu_r(7'h00, 3'b000, 5'd0, 5'd17, 5'd17));
    expect_store(store_op(3'b010, 5'd0, 5'd0, 12'h06c), 32'h6c, 32'h0000_0000, 4'b1111);
    // random addi chain into x18, running sum stored each step
    sum = '0;
    for (int k = 0; k < 10; k++) begin
      imm = 12'($random(seed));
      sum = sum + {{20{imm[11]}}, imm};
      push_instr(alu_i(3'b000, 5'd18, 5'd18, imm));
      expect_store(store_op(3'b010, 5'd18, 5'd0, 12'h0a0 + 12'(4 * k)),
                   addr_t'(32'ha0 + 4 * k), sum, 4'b1111);
    end
    for (int i = 0; i < program_rows.size(); i++) begin
      imem[i] = program_rows[i].instr;
      if (program_rows[i].has_store)
        expected_stores.push_back(program_rows[i].store);
    end
    imem_words = program_rows.size();

    cycles = 0;
    while (reset && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (reset)
      abort_run("timeout: reset was never released");
    // negedge, so the last edge's assertions have already been evaluated
    cycles = 0;
    while (store_count < expected_stores.size() && cycles < 500) begin
      @(negedge clk);
      cycles++;
    end
    if (store_count < expected_stores.size())
      abort_run($sformatf("timeout: only %0d of %0d expected stores were seen",
                          store_count, expected_stores.size()));
    // one repeated fetch per load-use pair
    if (repeat_count != expected_repeats) begin
      abort_run($sformatf("[FAIL] %0t ns: %0d repeated fetch addresses, expected %0d",
                          $time, repeat_count, expected_repeats));
    end else if (assertion_failures() != 0) begin
      abort_run("a bound assertion on the core ports failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/rv32_pipeline_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_pipeline_core_sva
  import rv32_pkg::*;
  ( input logic     clk
  , input logic     reset
  , input addr_t    memory_instr_address
  , input byte_en_t memory_data_write_enable
  );

  // failed checks so far, read by the testbench
  int failures = 0;

  // no stores while reset holds, first edge skipped as stages are still unknown
  no_store_in_reset: assert property (@(posedge clk)
    reset && $past(reset) |-> memory_data_write_enable == '0)
    else begin
      failures++;
      $error("data write enable set while reset is high");
    end

  // sw drives all four lanes, sb exactly one
  lane_shape: assert property (@(posedge clk) disable iff (reset)
    memory_data_write_enable inside {4'b0000, 4'b1111} || $onehot(memory_data_write_enable))
    else begin
      failures++;
      $error("data write enable is neither one lane nor all four");
    end

  // straight-line fetch, a stall repeats the address
  fetch_step: assert property (@(posedge clk) disable iff (reset)
    memory_instr_address == $past(memory_instr_address) ||
    memory_instr_address == $past(memory_instr_address) + 32'd4)
    else begin
      failures++;
      $error("instruction address moved by something other than 0 or 4");
    end

endmodule

bind rv32_pipeline_core rv32_pipeline_core_sva rv32_pipeline_core_sva_i (.*);

`default_nettype wire

/* verif/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen
  ( output logic clk
  , output logic reset
  );

  // 4 ns period, first rising edge at 2 ns
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // held over five rising edges, dropped 1 ns after the last one
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

/* hw/rv32_pipeline_core.sv */
`timescale 1ns/1ps
`default_nettype none

// five-stage in-order rv32 core, instruction and data ports read combinationally
module rv32_pipeline_core
  import rv32_pkg::*;
  ( input  logic     clk
  , input  logic     reset
  // instruction port
  , output addr_t    memory_instr_address
  , input  instr_t   memory_instr_read_data
  // data port
  , output addr_t    memory_data_address
  , output data_t    memory_data_write_data
  , output byte_en_t memory_data_write_enable
  , input  data_t    memory_data_read_data
  );

  // stage registers
  if_to_id_t  if_to_id;
  id_to_ex_t  id_to_ex;
  ex_to_mem_t ex_to_mem;
  mem_to_wb_t mem_to_wb;

  // hazard controls
  logic       stall;
  logic [1:0] fwd_a;
  logic [1:0] fwd_b;
  data_t      mem_forward;

  fetch fetch_i
    ( .clk           ( clk                    )
    , .reset         ( reset                  )
    , .stall         ( stall                  )
    , .instr_address ( memory_instr_address   )
    , .instr_data    ( memory_instr_read_data )
    , .if_to_id      ( if_to_id               )
    );

  // register file lives in here, written from mem_to_wb
  decode decode_i
    ( .clk      ( clk       )
    , .reset    ( reset     )
    , .stall    ( stall     )
    , .if_to_id ( if_to_id  )
    , .wb       ( mem_to_wb )
    , .id_to_ex ( id_to_ex  )
    );

  hazard_unit hazard_unit_i
    ( .if_to_id  ( if_to_id  )
    , .id_to_ex  ( id_to_ex  )
    , .ex_to_mem ( ex_to_mem )
    , .mem_to_wb ( mem_to_wb )
    , .stall     ( stall     )
    , .fwd_a     ( fwd_a     )
    , .fwd_b     ( fwd_b     )
    );

  // wb forward is the registered writeback result
  execute execute_i
    ( .clk               ( clk                      )
    , .reset             ( reset                    )
    , .id_to_ex          ( id_to_ex                 )
    , .fwd_a             ( fwd_a                    )
    , .fwd_b             ( fwd_b                    )
    , .mem_forward       ( mem_forward              )
    , .wb_forward        ( mem_to_wb.result         )
    , .ex_to_mem         ( ex_to_mem                )
    , .data_address      ( memory_data_address      )
    , .data_write_data   ( memory_data_write_data   )
    , .data_write_enable ( memory_data_write_enable )
    );

  write_back write_back_i
    ( .clk            ( clk                   )
    , .reset          ( reset                 )
    , .ex_to_mem      ( ex_to_mem             )
    , .data_read_data ( memory_data_read_data )
    , .mem_forward    ( mem_forward           )
    , .mem_to_wb      ( mem_to_wb             )
    );

endmodule

`default_nettype wire

/* hw/write_back.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back
  import rv32_pkg::*;
  ( input  logic       clk
  , input  logic       reset
  , input  ex_to_mem_t ex_to_mem
  , input  data_t      data_read_data
  , output data_t      mem_forward
  , output mem_to_wb_t mem_to_wb
  )
  ;

  // memory-stage result, also the forward into execute
  // dmem read is combinational so a load's word is already here
  assign mem_forward = ex_to_mem.mem_read ? data_read_data : ex_to_mem.alu_result;

  always_ff @(posedge clk) begin
    mem_to_wb.result <= mem_forward;
    mem_to_wb.rd     <= ex_to_mem.rd;
    if (reset)
      mem_to_wb.reg_write <= 1'b0;
    else
      mem_to_wb.reg_write <= ex_to_mem.reg_write;
  end

endmodule

`default_nettype wire

/* hw/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute
  import rv32_pkg::*;
  ( input  logic       clk
  , input  logic       reset
  , input  id_to_ex_t  id_to_ex
  , input  logic [1:0] fwd_a
  , input  logic [1:0] fwd_b
  , input  data_t      mem_forward
  , input  data_t      wb_forward
  , output ex_to_mem_t ex_to_mem
  , output addr_t      data_address
  , output data_t      data_write_data
  , output byte_en_t   data_write_enable
  );

  data_t      op_a;
  data_t      rs2_fwd;
  data_t      op_b;
  data_t      alu_result;
  data_t      store_data;
  ex_to_mem_t ex_next;

  function automatic data_t fwd_mux
    ( logic [1:0] sel
    , data_t      reg_val
    , data_t      mem_val
    , data_t      wb_val
    );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // operands, forwarded where hazard_unit says so
  assign op_a    = fwd_mux(fwd_a, id_to_ex.rs1_val, mem_forward, wb_forward);
  assign rs2_fwd = fwd_mux(fwd_b, id_to_ex.rs2_val, mem_forward, wb_forward);
  assign op_b    = id_to_ex.use_imm ? id_to_ex.imm : rs2_fwd;

  always_comb begin
    case (id_to_ex.alu_op)
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // sb puts the byte on every lane, the enable picks one
  assign store_data = id_to_ex.mem_byte ? {4{rs2_fwd[7:0]}} : rs2_fwd;

  always_comb begin
    ex_next            = '0;
    ex_next.alu_result = alu_result;
    ex_next.store_data = store_data;
    ex_next.rd         = id_to_ex.rd;
    ex_next.mem_read   = id_to_ex.mem_read;
    ex_next.mem_write  = id_to_ex.mem_write;
    ex_next.mem_byte   = id_to_ex.mem_byte;
    ex_next.reg_write  = id_to_ex.reg_write;
  end

  always_ff @(posedge clk) begin
    ex_to_mem <= ex_next;
    if (reset) begin
      ex_to_mem.mem_read  <= 1'b0;
      ex_to_mem.mem_write <= 1'b0;
      ex_to_mem.mem_byte  <= 1'b0;
      ex_to_mem.reg_write <= 1'b0;
    end
  end

  // data port comes straight off the stage register
  assign data_address    = ex_to_mem.alu_result;
  assign data_write_data = ex_to_mem.store_data;

  always_comb begin
    if (!ex_to_mem.mem_write)
      data_write_enable = '0;
    else if (ex_to_mem.mem_byte)
      // lane = address bits 1:0
      data_write_enable = byte_en_t'(4'b0001 << ex_to_mem.alu_result[1:0]);
    else
      data_write_enable = 4'b1111;
  end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import rv32_pkg::*;
  ( input  if_to_id_t  if_to_id
  , input  id_to_ex_t  id_to_ex
  , input  ex_to_mem_t ex_to_mem
  , input  mem_to_wb_t mem_to_wb
  , output logic       stall
  , output logic [1:0] fwd_a
  , output logic [1:0] fwd_b
  );

  logic [6:0] dec_opcode;
  reg_idx_t   dec_rs1;
  reg_idx_t   dec_rs2;
  logic       dec_uses_rs1;
  logic       dec_uses_rs2;

  // youngest producer wins, x0 never forwards
  function automatic logic [1:0] fwd_select
    ( reg_idx_t   src
    , ex_to_mem_t mem
    , mem_to_wb_t wb
    );
    if (mem.reg_write && mem.rd != '0 && mem.rd == src)
      return FWD_MEM;
    else if (wb.reg_write && wb.rd != '0 && wb.rd == src)
      return FWD_WB;
    else
      return FWD_NONE;
  endfunction

  assign fwd_a = fwd_select(id_to_ex.rs1, ex_to_mem, mem_to_wb);
  assign fwd_b = fwd_select(id_to_ex.rs2, ex_to_mem, mem_to_wb);

  // source fields of the word sitting in decode
  assign dec_opcode = if_to_id.instr[6:0];
  assign dec_rs1    = if_to_id.instr[19:15];
  assign dec_rs2    = if_to_id.instr[24:20];

  // lui has no rs1, only r-type and stores read rs2
  assign dec_uses_rs1 = (dec_opcode != OPC_LUI);
  assign dec_uses_rs2 = (dec_opcode == OPC_OP) || (dec_opcode == OPC_STORE);

  // load in execute feeding the next instruction, one bubble needed
  assign stall = id_to_ex.mem_read && id_to_ex.rd != '0 &&
                 ((dec_uses_rs1 && id_to_ex.rd == dec_rs1) ||
                  (dec_uses_rs2 && id_to_ex.rd == dec_rs2));

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode
  import rv32_pkg::*;
  ( input  logic       clk
  , input  logic       reset
  , input  logic       stall
  , input  if_to_id_t  if_to_id
  , input  mem_to_wb_t wb
  , output id_to_ex_t  id_to_ex
  );

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_u;
  data_t      rs1_val;
  data_t      rs2_val;
  id_to_ex_t  id_next;

  // instruction fields
  assign opcode = if_to_id.instr[6:0];
  assign rd     = if_to_id.instr[11:7];
  assign funct3 = if_to_id.instr[14:12];
  assign rs1    = if_to_id.instr[19:15];
  assign rs2    = if_to_id.instr[24:20];
  assign funct7 = if_to_id.instr[31:25];

  // sign-extended I and S, U is upper 20 bits
  assign imm_i = {{20{if_to_id.instr[31]}}, if_to_id.instr[31:20]};
  assign imm_s = {{20{if_to_id.instr[31]}}, if_to_id.instr[31:25], if_to_id.instr[11:7]};
  assign imm_u = {if_to_id.instr[31:12], 12'b0};

  register_file register_file_i
    ( .clk     ( clk     )
    , .reset   ( reset   )
    , .rs1     ( rs1     )
    , .rs2     ( rs2     )
    , .rs1_val ( rs1_val )
    , .rs2_val ( rs2_val )
    , .wb      ( wb      )
    );

  always_comb begin
    // control bits start cleared, so anything unmatched is a bubble
    id_next         = '0;
    id_next.rs1_val = rs1_val;
    id_next.rs2_val = rs2_val;
    id_next.rs1     = rs1;
    id_next.rs2     = rs2;
    id_next.rd      = rd;
    id_next.imm     = imm_i;
    case (opcode)
      OPC_OP: begin
        id_next.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: id_next.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: id_next.alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: id_next.alu_op = ALU_AND;
          {7'b0000000, 3'b110}: id_next.alu_op = ALU_OR;
          {7'b0000000, 3'b100}: id_next.alu_op = ALU_XOR;
          default:              id_next.reg_write = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        id_next.use_imm   = 1'b1;
        id_next.reg_write = 1'b1;
        case (funct3)
          3'b000:  id_next.alu_op = ALU_ADD;
          3'b111:  id_next.alu_op = ALU_AND;
          3'b110:  id_next.alu_op = ALU_OR;
          3'b100:  id_next.alu_op = ALU_XOR;
          // slti, shifts and the like are not supported
          default: begin
            id_next.use_imm   = 1'b0;
            id_next.reg_write = 1'b0;
          end
        endcase
      end
      OPC_LUI: begin
        id_next.imm       = imm_u;
        id_next.alu_op    = ALU_PASS_B;
        id_next.use_imm   = 1'b1;
        id_next.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        // lw only
        if (funct3 == 3'b010) begin
          id_next.use_imm   = 1'b1;
          id_next.mem_read  = 1'b1;
          id_next.reg_write = 1'b1;
        end
      end
      OPC_STORE: begin
        id_next.imm = imm_s;
        // sw or sb, address is rs1 + imm_s
        if (funct3 == 3'b010 || funct3 == 3'b000) begin
          id_next.use_imm   = 1'b1;
          id_next.mem_write = 1'b1;
          id_next.mem_byte  = (funct3 == 3'b000);
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    id_to_ex <= id_next;
    // load-use stall sends a bubble, the same word decodes again next cycle
    if (reset || stall) begin
      id_to_ex.alu_op    <= ALU_ADD;
      id_to_ex.use_imm   <= 1'b0;
      id_to_ex.mem_read  <= 1'b0;
      id_to_ex.mem_write <= 1'b0;
      id_to_ex.mem_byte  <= 1'b0;
      id_to_ex.reg_write <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
  import rv32_pkg::*;
  ( input  logic       clk
  , input  logic       reset
  , input  reg_idx_t   rs1
  , input  reg_idx_t   rs2
  , output data_t      rs1_val
  , output data_t      rs2_val
  , input  mem_to_wb_t wb
  );

  // x1..x31, x0 has no storage
  data_t regs [1:31];

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic data_t read_reg(reg_idx_t idx);
    if (idx == '0)
      return '0;
    else if (wb.reg_write && wb.rd == idx)
      return wb.result;
    else
      return regs[idx];
  endfunction

  assign rs1_val = read_reg(rs1);
  assign rs2_val = read_reg(rs2);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.result;
    end
  end

endmodule

`default_nettype wire

/* hw/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch
  import rv32_pkg::*;
  ( input  logic      clk
  , input  logic      reset
  , input  logic      stall
  , output addr_t     instr_address
  , input  instr_t    instr_data
  , output if_to_id_t if_to_id
  );

  // program counter, no branches so it only ever steps by 4
  addr_t pc;

  // imem answers in the same cycle
  assign instr_address = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc             <= RESET_PC;
      // decode sees a nop until the first real word arrives
      if_to_id.pc    <= RESET_PC;
      if_to_id.instr <= NOP_INSTR;
    end else if (!stall) begin
      pc             <= pc + addr_t'(4);
      if_to_id.pc    <= pc;
      if_to_id.instr <= instr_data;
    end
    // stall: pc and fetched word both hold, address repeats next cycle
  end

endmodule

`default_nettype wire

/* hw/rv32_pkg.sv */
`default_nettype none

package rv32_pkg;

  // plain vector types for the widths the core passes around
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [2:0]  alu_op_t;

  // alu operation codes
  localparam alu_op_t ALU_ADD    = 3'd0;
  localparam alu_op_t ALU_SUB    = 3'd1;
  localparam alu_op_t ALU_AND    = 3'd2;
  localparam alu_op_t ALU_OR     = 3'd3;
  localparam alu_op_t ALU_XOR    = 3'd4;
  // lui: result is the immediate
  localparam alu_op_t ALU_PASS_B = 3'd5;

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  localparam addr_t  RESET_PC  = 32'h0000_0000;
  // addi x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

  // execute operand source
  localparam logic [1:0] FWD_NONE = 2'd0;
  localparam logic [1:0] FWD_MEM  = 2'd1;
  localparam logic [1:0] FWD_WB   = 2'd2;

  typedef struct packed {
    addr_t  pc;
    instr_t instr;
  } if_to_id_t;

  typedef struct packed {
    data_t    rs1_val;
    data_t    rs2_val;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    data_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     mem_read;
    logic     mem_write;
    // sb when set, sw otherwise
    logic     mem_byte;
    logic     reg_write;
  } id_to_ex_t;

  typedef struct packed {
    data_t    alu_result;
    // already lane-replicated for sb
    data_t    store_data;
    reg_idx_t rd;
    logic     mem_read;
    logic     mem_write;
    logic     mem_byte;
    logic     reg_write;
  } ex_to_mem_t;

  typedef struct packed {
    data_t    result;
    reg_idx_t rd;
    logic     reg_write;
  } mem_to_wb_t;

endpackage

`default_nettype wire
